//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_uart_rx_multi \
		-f uart_rx_multi.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/uart_rx_lane.sv
// uart receive lane that frames 8N1 characters and holds the last one until the merger takes it.
`timescale 1ns/10ps
`default_nettype none

module uart_rx_lane
    import uart_rx_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  wire       clk_i,
    input  wire       rst_i,
    input  wire baud_div_t baud_div_i,
    input  wire       rx_i,
    input  wire       take_i,
    output rx_rec_t   rec_o,
    output logic      valid_o,
    output logic      overrun_o
);

    lane_state_t state;
    baud_div_t   baud_cnt;
    logic [2:0]  bit_cnt;
    char_t       shift;
    logic        stop_bit;
    logic        rx_prev;
    logic        tick;

    assign tick = (baud_cnt == '0);  // sample point of the current bit.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rx_prev  <= 1'b1;
        end else begin
            rx_prev <= rx_i;
            case (state)
                idle: begin
                    // a falling edge realigns the counter to the middle of the start bit.
                    if (rx_prev && !rx_i) begin
                        baud_cnt <= baud_div_i >> 1;
                        state    <= start;
                    end
                end
                start: begin
                    if (tick) begin
                        baud_cnt <= baud_div_i;
                        bit_cnt  <= '0;
                        state    <= rx_i ? idle : data;  // a high line was only noise.
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                data: begin
                    if (tick) begin
                        baud_cnt <= baud_div_i;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                stop: begin
                    if (tick) begin
                        state <= hold;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                hold: begin
                    state <= idle;  // the character is published on this cycle.
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // data bits arrive lsb first.
    always_ff @(posedge clk_i) begin
        if (state == data && tick) begin
            shift <= {rx_i, shift[7:1]};
        end
        if (state == stop && tick) begin
            stop_bit <= rx_i;
        end
        if (state == hold) begin
            rec_o <= '{lane: 4'(LANE_ID), frame_err: ~stop_bit, data: shift};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            overrun_o <= 1'b0;
        end else begin
            if (take_i) begin
                valid_o <= 1'b0;
            end
            if (state == hold) begin
                valid_o <= 1'b1;
                // an untaken character is lost to the new one.
                if (valid_o && !take_i) begin
                    overrun_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx_merge.sv
// uart lane merger that grants lanes round-robin into one shared first-word-fall-through queue.
`timescale 1ns/10ps
`default_nettype none

module uart_rx_merge
    import uart_rx_pkg::*;
#(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire rx_rec_t [NUM_LANES-1:0] lane_rec_i,
    input  wire [NUM_LANES-1:0]          lane_valid_i,
    output logic [NUM_LANES-1:0]         take_o,
    input  wire                          re_i,
    output rx_rec_t                      rec_o,
    output logic                         empty_o,
    output logic                         full_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int ADDR_W = $clog2(QUEUE_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;  // extra bit tells full from empty.

    rx_rec_t queue [QUEUE_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [LANE_W-1:0] rr_ptr;
    logic [LANE_W-1:0] grant_idx;
    logic              grant_any;
    logic              grant_en;

    function automatic logic [LANE_W-1:0] wrap_add(input logic [LANE_W-1:0] base,
                                                   input int offs);
        int sum;
        sum = int'(base) + offs;
        if (sum >= NUM_LANES) begin
            sum = sum - NUM_LANES;
        end
        return LANE_W'(sum);
    endfunction

    // walking down leaves the closest valid lane at or after rr_ptr as the winner.
    always_comb begin
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lane_valid_i[wrap_add(rr_ptr, i)]) begin
                grant_any = 1'b1;
                grant_idx = wrap_add(rr_ptr, i);
            end
        end
    end

    assign grant_en = grant_any && !full_o;

    always_comb begin
        take_o = '0;
        if (grant_en) begin
            take_o[grant_idx] = 1'b1;
        end
    end

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign rec_o   = queue[rd_ptr[ADDR_W-1:0]];  // head is visible without a read.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rr_ptr <= '0;
        end else begin
            if (grant_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                rr_ptr <= wrap_add(grant_idx, 1);
            end
            if (re_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_en) begin
            queue[wr_ptr[ADDR_W-1:0]] <= lane_rec_i[grant_idx];
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx_multi.sv
// multi-lane uart receiver with per-lane framing merged into one tagged character queue.
`timescale 1ns/10ps
`default_nettype none

module uart_rx_multi
    import uart_rx_pkg::*;
#(
    parameter int NUM_LANES   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire baud_div_t       baud_div_i,
    input  wire [NUM_LANES-1:0]  rx_i,
    input  wire                  re_i,
    output wire rx_rec_t         rec_o,
    output wire                  empty_o,
    output wire                  full_o,
    output wire [NUM_LANES-1:0]  overrun_o
);

    wire [NUM_LANES-1:0]          rx_clean;
    wire rx_rec_t [NUM_LANES-1:0] lane_rec;
    wire [NUM_LANES-1:0]          lane_valid;
    wire [NUM_LANES-1:0]          lane_take;

    uart_rx_sync #(
        .NUM_LANES(NUM_LANES)
    ) uart_rx_sync_i (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .rx_i (rx_i),
        .rx_o (rx_clean)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        uart_rx_lane #(
            .LANE_ID(k)
        ) uart_rx_lane_i (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .baud_div_i(baud_div_i),
            .rx_i      (rx_clean[k]),
            .take_i    (lane_take[k]),
            .rec_o     (lane_rec[k]),
            .valid_o   (lane_valid[k]),
            .overrun_o (overrun_o[k])
        );
    end

    uart_rx_merge #(
        .NUM_LANES  (NUM_LANES),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) uart_rx_merge_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .lane_rec_i  (lane_rec),
        .lane_valid_i(lane_valid),
        .take_o      (lane_take),
        .re_i        (re_i),
        .rec_o       (rec_o),
        .empty_o     (empty_o),
        .full_o      (full_o)
    );

endmodule

`default_nettype wire

//--- logic/uart_rx_pkg.sv
// uart receive package with the shared widths, the lane state encoding and the queue record.
`default_nettype none

package uart_rx_pkg;

    // clock cycles per bit minus one.
    typedef logic [15:0] baud_div_t;

    typedef logic [7:0] char_t;

    // a lane walks through these once per character.
    typedef enum logic [2:0] {
        idle,
        start,
        data,
        stop,
        hold
    } lane_state_t;

    // one finished character as it sits in the shared queue.
    typedef struct packed {
        logic [3:0] lane;       // at most 16 lanes.
        logic       frame_err;  // stop bit was sampled low.
        char_t      data;
    } rx_rec_t;

endpackage

`default_nettype wire

//--- logic/uart_rx_sync.sv
// uart input conditioner with a two-flop synchronizer and a three-sample glitch filter per line.
`timescale 1ns/10ps
`default_nettype none

module uart_rx_sync #(
    parameter int NUM_LANES = 4
) (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire [NUM_LANES-1:0]  rx_i,
    output logic [NUM_LANES-1:0] rx_o
);

    logic [NUM_LANES-1:0] sync_q1;
    logic [NUM_LANES-1:0] sync_q2;
    logic [NUM_LANES-1:0] hist_q1;
    logic [NUM_LANES-1:0] hist_q2;

    // all stages come out of reset at the idle line level.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q1 <= '1;
            sync_q2 <= '1;
            hist_q1 <= '1;
            hist_q2 <= '1;
        end else begin
            sync_q1 <= rx_i;
            sync_q2 <= sync_q1;
            hist_q1 <= sync_q2;
            hist_q2 <= hist_q1;
        end
    end

    // bitwise two out of three vote, so a single-cycle pulse never wins.
    assign rx_o = (sync_q2 & hist_q1) | (sync_q2 & hist_q2) | (hist_q1 & hist_q2);

endmodule

`default_nettype wire

//--- tb/tb_uart_rx_multi.sv
// testbench for the multi-lane uart receiver with a serial-line model and a draining reader.
`timescale 1ns/10ps
`default_nettype none

module tb_uart_rx_multi
    import uart_rx_pkg::*;
();

    localparam int NUM_LANES = 4;
    localparam int DIV_A     = 7;
    localparam int DIV_B     = 20;
    localparam int FRAME_A   = 10 * (DIV_A + 1);
    localparam int FRAME_B   = 10 * (DIV_B + 1);
    // serial time of all tests, in frames at DIV_A plus the one frame at DIV_B.
    localparam int TEST_CYCLES = FRAME_A * (1 + 16 + 1 + 2 + 6) + FRAME_B;
    localparam int TIMEOUT     = TEST_CYCLES * 2 + 2000;

    logic                 clk;
    logic                 rst      = 1'b1;
    baud_div_t            baud_div = 16'(DIV_A);
    logic [NUM_LANES-1:0] rx       = '1;
    logic                 re       = 1'b0;
    rx_rec_t              rec;
    logic                 empty;
    logic                 full;
    logic [NUM_LANES-1:0] overrun;

    rx_rec_t     expected[$];
    char_t       burst [NUM_LANES][16];
    logic [31:0] rng           = 32'd94843;
    logic        drain_en      = 1'b0;
    int          checks        = 0;
    int          errors        = 0;
    int          errs_at_start = 0;
    int          cycles        = 0;

    uart_rx_multi #(
        .NUM_LANES  (NUM_LANES),
        .QUEUE_DEPTH(16)
    ) uart_rx_multi_i (
        .clk_i     (clk),
        .rst_i     (rst),
        .baud_div_i(baud_div),
        .rx_i      (rx),
        .re_i      (re),
        .rec_o     (rec),
        .empty_o   (empty),
        .full_o    (full),
        .overrun_o (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the receiver never finished the tests", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rx_rec_t make_rec(input int lane, input logic bad, input char_t ch);
        rx_rec_t r;
        r = '{lane: 4'(lane), frame_err: bad, data: ch};
        return r;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("** Error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic draw_char(output char_t ch);
        rng = xorshift32(rng);
        ch  = rng[7:0];
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s", name, (errors == errs_at_start) ? "passed" : "failed");
        errs_at_start = errors;
    endtask

    // one 8N1 frame, lsb first, bit changes on the falling edge.
    task automatic send_frame(input int lane, input char_t ch, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, ch, 1'b0};
        for (int b = 0; b < 10; b++) begin
            rx[lane] = bits[b];
            repeat (int'(baud_div) + 1) @(negedge clk);
        end
        rx[lane] = 1'b1;
    endtask

    task automatic send_expected(input int lane, input char_t ch, input logic bad_stop);
        expected.push_back(make_rec(lane, bad_stop, ch));
        send_frame(lane, ch, bad_stop);
    endtask

    task automatic send_burst(input int lane, input int count, input logic record);
        for (int i = 0; i < count; i++) begin
            if (record) begin
                expected.push_back(make_rec(lane, 1'b0, burst[lane][i]));
            end
            send_frame(lane, burst[lane][i], 1'b0);
        end
    endtask

    task automatic send_all_lanes(input int count, input logic record);
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int i = 0; i < count; i++) begin
                draw_char(burst[k][i]);
            end
        end
        fork
            send_burst(0, count, record);
            send_burst(1, count, record);
            send_burst(2, count, record);
            send_burst(3, count, record);
        join
    endtask

    // lane order is free across lanes, so the oldest entry of the popped lane must match.
    task automatic match_record(input rx_rec_t got);
        int idx;
        idx = -1;
        for (int i = 0; i < expected.size(); i++) begin
            if (idx < 0 && expected[i].lane == got.lane) begin
                idx = i;
            end
        end
        check(idx >= 0, $sformatf("record %02h on lane %0d was not expected", got.data, got.lane));
        if (idx >= 0) begin
            check(got == expected[idx],
                  $sformatf("lane %0d popped err %0b data %02h, expected %0b %02h",
                            got.lane, got.frame_err, got.data,
                            expected[idx].frame_err, expected[idx].data));
            expected.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && drain_en && !empty) begin
            match_record(rec);
            re = 1'b1;
        end else begin
            re = 1'b0;
        end
    end

    task automatic wait_drained();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        check(empty == 1'b1, "queue not empty after all expected records were popped");
    endtask

    initial begin
        char_t ch;
        int    n;
        logic  glitch_seen;
        repeat (8) @(negedge clk);
        rst      = 1'b0;
        drain_en = 1'b1;

        draw_char(ch);
        send_expected(2, ch, 1'b0);
        wait_drained();
        finish_test("test 1 single character on lane 2");

        send_all_lanes(16, 1'b1);
        wait_drained();
        check(overrun == '0, $sformatf("overrun %04b while the reader kept up", overrun));
        finish_test("test 2 sixteen characters on all lanes");

        draw_char(ch);
        send_expected(1, ch, 1'b1);
        repeat (DIV_A + 1) @(negedge clk);  // idle gap after the low stop bit.
        wait_drained();
        finish_test("test 3 low stop bit");

        glitch_seen = 1'b0;
        rx[3] = 1'b0;
        @(negedge clk);
        rx[3] = 1'b1;
        for (int i = 0; i < 2 * FRAME_A; i++) begin
            @(negedge clk);
            glitch_seen = glitch_seen | ~empty;
        end
        check(!glitch_seen, "empty_o fell after a one-cycle pulse on lane 3");
        finish_test("test 4 glitch rejection");

        drain_en = 1'b0;
        send_all_lanes(4, 1'b1);
        n = 0;
        while (!full && n < FRAME_A) begin
            @(negedge clk);
            n++;
        end
        check(full == 1'b1, "full_o did not rise after 16 records");
        send_all_lanes(1, 1'b0);
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k != 1) begin
                expected.push_back(make_rec(k, 1'b0, burst[k][0]));
            end
        end
        check(overrun == '0, $sformatf("overrun %04b before any character was lost", overrun));
        draw_char(ch);
        send_expected(1, ch, 1'b0);  // replaces the held character on lane 1.
        n = 0;
        while (!overrun[1] && n < FRAME_A) begin
            @(negedge clk);
            n++;
        end
        check(overrun == 4'b0010, $sformatf("overrun %04b, expected 0010", overrun));
        check(full == 1'b1, "full_o fell while nothing was read");
        drain_en = 1'b1;
        wait_drained();
        finish_test("test 5 back-pressure and overrun");

        baud_div = 16'(DIV_B);
        draw_char(ch);
        send_expected(0, ch, 1'b0);
        wait_drained();
        finish_test("test 6 divisor of 20 on lane 0");

        $display("checks passed: %0d, errors: %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_rx_multi.f
logic/uart_rx_pkg.sv
logic/uart_rx_sync.sv
logic/uart_rx_lane.sv
logic/uart_rx_merge.sv
logic/uart_rx_multi.sv
tb/tb_uart_rx_multi.sv
